// File: files.f
+incdir+.
cache_pkg.sv
mem_pkg.sv
sram.sv
line_fill_router.sv
line_drain.sv
l1_cache_controller.sv
l1_cache.sv
tb_l1_cache.sv

// File: Bender.yml
package:
  name: l1_cache

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cache_pkg.sv
      - mem_pkg.sv
      - sram.sv
      - line_fill_router.sv
      - line_drain.sv
      - l1_cache_controller.sv
      - l1_cache.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_l1_cache.sv

// File: tb_l1_cache.sv
`include "cache_defs.svh"

module tb_l1_cache
	import cache_pkg::*, mem_pkg::*;
();

	localparam int CYCLE = 20;
	localparam int RESET_CYCLES = 8;
	localparam int DRIVE_DLY = 2;
	localparam int ACK_MAX = 6;
	localparam int DIRECTED_N = 16;
	localparam int RAND_N = 48;
	localparam int TBL_LEN = DIRECTED_N + RAND_N;
	localparam int MEM_LINES = 64;
	localparam int OFF_W = `CACHE_ADDR_W - `CACHE_TAG_W - `CACHE_INDEX_W;
	localparam int TIMEOUT = TBL_LEN * (2 * ACK_MAX + 2 * ACK_MAX + 4) * CYCLE
		+ RESET_CYCLES * CYCLE;

	typedef logic [`CACHE_ADDR_W-1:0] addr_t;

	// one table row, stimulus plus what the reference model predicts
	typedef struct packed {
		logic  we;
		addr_t addr;
		word_t data;
		word_t exp_data;
		logic  exp_miss;
		logic  exp_wb;
		addr_t exp_wb_addr;
		line_t exp_wb_line;
	} entry_t;

	logic  clk = 1'b0;
	logic  arst_n_i = 1'b0;
	logic  cs_i = 1'b0;
	logic  we_i = 1'b0;
	addr_t addr_i = '0;
	word_t data_i = '0;
	word_t data_o;
	logic  stall_o;
	logic  mem_cs_o;
	logic  mem_we_o;
	addr_t mem_addr_o;
	line_t mem_data_o;
	line_t mem_data_i = '0;
	logic  mem_ack_i = 1'b0;

	line_t  mem_q [MEM_LINES];
	word_t  ref_words [MEM_LINES * `CACHE_LINE_WORDS];
	logic [`CACHE_SETS-1:0] ref_valid = '0;
	logic [`CACHE_SETS-1:0] ref_dirty = '0;
	tag_t   ref_tag [`CACHE_SETS];
	entry_t tbl [TBL_LEN];
	int     tbl_n = 0;
	int     exp_wb_total = 0;

	addr_t wb_addr_q [$];
	line_t wb_line_q [$];
	int rd_count = 0;
	int wr_count = 0;
	int checks = 0;
	int value_errors = 0;
	int other_errors = 0;

	always #(CYCLE / 2) clk = ~clk;

	l1_cache l1_cache_inst (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.cs_i       (cs_i),
		.we_i       (we_i),
		.addr_i     (addr_i),
		.data_i     (data_i),
		.data_o     (data_o),
		.stall_o    (stall_o),
		.mem_cs_o   (mem_cs_o),
		.mem_we_o   (mem_we_o),
		.mem_addr_o (mem_addr_o),
		.mem_data_o (mem_data_o),
		.mem_data_i (mem_data_i),
		.mem_ack_i  (mem_ack_i)
	);

	function automatic addr_t make_addr(input int tag, input int idx, input int woff);
		return {tag_t'(tag), index_t'(idx), woff_t'(woff), 2'b00};
	endfunction

	// model line number from tag bits 1:0 and index bits 3:0
	function automatic int mem_line(input addr_t addr);
		return int'({addr[11:10], addr[8:5]});
	endfunction

	function automatic logic in_range(input addr_t addr);
		return (addr[31:12] == '0) && !addr[9];
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_line(input string name, input line_t got, input line_t exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			value_errors++;
			$display("ERROR t=%0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic report_counts();
		$display("checks %0d, value errors %0d, other errors %0d",
			checks, value_errors, other_errors);
	endtask

	// reference model step, fills one table row
	task automatic add_entry(input logic we, input addr_t addr, input word_t data);
		entry_t e;
		index_t idx;
		tag_t tag;
		int widx;
		int vline;
		idx = addr[OFF_W +: `CACHE_INDEX_W];
		tag = addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
		widx = mem_line(addr) * `CACHE_LINE_WORDS + int'(addr[4:2]);
		e = '0;
		e.we = we;
		e.addr = addr;
		e.data = data;
		e.exp_miss = !ref_valid[idx] || (ref_tag[idx] != tag);
		e.exp_wb = e.exp_miss && ref_valid[idx] && ref_dirty[idx];
		if (e.exp_wb) begin
			e.exp_wb_addr = {ref_tag[idx], idx, {OFF_W{1'b0}}};
			vline = mem_line(e.exp_wb_addr);
			for (int k = 0; k < `CACHE_LINE_WORDS; k++) begin
				e.exp_wb_line[k*`CACHE_WORD_W +: `CACHE_WORD_W] =
					ref_words[vline * `CACHE_LINE_WORDS + k];
			end
			exp_wb_total++;
		end
		// refill brings the line in clean
		if (e.exp_miss) begin
			ref_valid[idx] = 1'b1;
			ref_tag[idx] = tag;
			ref_dirty[idx] = 1'b0;
		end
		if (we) begin
			ref_words[widx] = data;
			ref_dirty[idx] = 1'b1;
		end
		e.exp_data = ref_words[widx];
		tbl[tbl_n] = e;
		tbl_n++;
	endtask

	// line memory, acks each request after 1 to ACK_MAX cycles
	always begin : mem_model
		int delay;
		int lnum;
		logic is_write;
		@(negedge clk);
		if (mem_cs_o === 1'b1) begin
			is_write = mem_we_o;
			lnum = mem_line(mem_addr_o);
			if (!in_range(mem_addr_o)) begin
				other_errors++;
				$display("memory access at %h lies outside the 64 modeled lines", mem_addr_o);
			end
			delay = $urandom_range(ACK_MAX, 1);
			repeat (delay) @(posedge clk);
			#DRIVE_DLY;
			if (is_write) begin
				mem_q[lnum] = mem_data_o;
				wb_addr_q.push_back(mem_addr_o);
				wb_line_q.push_back(mem_data_o);
				wr_count++;
			end else begin
				mem_data_i = mem_q[lnum];
				rd_count++;
			end
			mem_ack_i = 1'b1;
			@(posedge clk);
			#DRIVE_DLY;
			mem_ack_i = 1'b0;
		end
	end

	initial begin : watchdog
		#(TIMEOUT);
		other_errors++;
		$display("timeout, the stimulus table did not finish within %0d time units", TIMEOUT);
		report_counts();
		$display("sim failed");
		$finish;
	end

	initial begin : stimulus
		entry_t e;
		word_t got;
		int rd0;
		int wr0;
		int cycles;
		int rand_idx [4];
		void'($urandom(32'he934_52ed));
		for (int l = 0; l < MEM_LINES; l++) begin
			for (int k = 0; k < `CACHE_LINE_WORDS; k++) begin
				mem_q[l][k*`CACHE_WORD_W +: `CACHE_WORD_W] = $urandom;
				ref_words[l * `CACHE_LINE_WORDS + k] = mem_q[l][k*`CACHE_WORD_W +: `CACHE_WORD_W];
			end
		end

		// untouched line, every word
		for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
			add_entry(1'b0, make_addr(1, 2, w), '0);
		end
		// store, load back, then another word of the same line
		add_entry(1'b1, make_addr(0, 4, 3), 32'h1234_5678);
		add_entry(1'b0, make_addr(0, 4, 3), '0);
		add_entry(1'b0, make_addr(0, 4, 5), '0);
		// same index, new tag evicts the dirty line
		add_entry(1'b1, make_addr(2, 6, 1), 32'hdead_beef);
		add_entry(1'b0, make_addr(3, 6, 0), '0);
		add_entry(1'b0, make_addr(2, 6, 1), '0);
		// clean victim on index 8
		add_entry(1'b0, make_addr(0, 8, 0), '0);
		add_entry(1'b0, make_addr(1, 8, 2), '0);

		// mixed traffic, 4 tags over 4 indices
		rand_idx = '{1, 6, 11, 15};
		for (int i = 0; i < RAND_N; i++) begin
			add_entry(1'($urandom_range(1, 0)),
				make_addr($urandom_range(3, 0), rand_idx[$urandom_range(3, 0)],
					$urandom_range(7, 0)),
				$urandom);
		end

		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		arst_n_i = 1'b1;
		@(negedge clk);
		check_bit("stall_o", stall_o, 1'b0);
		check_bit("mem_cs_o", mem_cs_o, 1'b0);
		check_bit("mem_we_o", mem_we_o, 1'b0);
		@(posedge clk);
		#DRIVE_DLY;

		for (int i = 0; i < tbl_n; i++) begin
			e = tbl[i];
			cs_i = 1'b1;
			we_i = e.we;
			addr_i = e.addr;
			data_i = e.data;
			rd0 = rd_count;
			wr0 = wr_count;
			cycles = 0;
			// stall low at the falling edge marks the completion edge
			do begin
				@(negedge clk);
				cycles++;
			end while (stall_o !== 1'b0);
			got = data_o;
			@(posedge clk);
			#DRIVE_DLY;
			if (!e.we) begin
				check_word("data_o", got, e.exp_data);
			end
			if (!e.exp_miss) begin
				check_count("hit_latency", cycles, 2);
			end
			check_count("mem_reads", rd_count - rd0, e.exp_miss ? 1 : 0);
			check_count("mem_writes", wr_count - wr0, e.exp_wb ? 1 : 0);
			if (e.exp_wb && (wr_count - wr0 == 1)) begin
				check_addr("mem_addr_o", wb_addr_q[$], e.exp_wb_addr);
				check_line("mem_data_o", wb_line_q[$], e.exp_wb_line);
			end
		end
		cs_i = 1'b0;
		we_i = 1'b0;

		repeat (2) @(posedge clk);
		check_count("write_backs", wb_addr_q.size(), exp_wb_total);
		report_counts();
		if (value_errors == 0 && other_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: l1_cache.sv
`include "cache_defs.svh"

module l1_cache
	import cache_pkg::*, mem_pkg::*;
(
	input  logic                     clk,
	input  logic                     arst_n_i,

	// cpu port
	input  logic                     cs_i,
	input  logic                     we_i,
	input  logic [`CACHE_ADDR_W-1:0] addr_i,
	input  word_t                    data_i,
	output word_t                    data_o,
	output logic                     stall_o,

	// line-wide memory port
	output logic                     mem_cs_o,
	output logic                     mem_we_o,
	output logic [`CACHE_ADDR_W-1:0] mem_addr_o,
	output line_t                    mem_data_o,
	input  line_t                    mem_data_i,
	input  logic                     mem_ack_i
);

	localparam int OFF_W = `CACHE_ADDR_W - `CACHE_TAG_W - `CACHE_INDEX_W;
	localparam int BYTE_W = OFF_W - `CACHE_WOFF_W;

	// tag entry is {dirty, tag}
	localparam int TAG_ENTRY_W = `CACHE_TAG_W + 1;

	tag_t req_tag;
	index_t req_index;
	woff_t req_woff;

	logic tag_we;
	logic tag_dirty;
	logic ram_cs;
	logic fill_sel;
	logic word_we;

	logic [TAG_ENTRY_W-1:0] tag_wdata;
	logic [TAG_ENTRY_W-1:0] tag_rdata;
	tag_t stored_tag;
	logic stored_dirty;

	logic [`CACHE_LINE_WORDS-1:0] bank_we;
	word_t [`CACHE_LINE_WORDS-1:0] bank_wdata;
	word_t [`CACHE_LINE_WORDS-1:0] bank_rdata;

	// address split, low byte bits dropped
	assign req_tag = addr_i[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
	assign req_index = addr_i[OFF_W +: `CACHE_INDEX_W];
	assign req_woff = addr_i[BYTE_W +: `CACHE_WOFF_W];

	assign tag_wdata = {tag_dirty, req_tag};
	assign stored_dirty = tag_rdata[`CACHE_TAG_W];
	assign stored_tag = tag_rdata[`CACHE_TAG_W-1:0];

	l1_cache_controller controller_inst (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.cs_i           (cs_i),
		.we_i           (we_i),
		.tag_i          (req_tag),
		.index_i        (req_index),
		.stored_tag_i   (stored_tag),
		.stored_dirty_i (stored_dirty),
		.mem_ack_i      (mem_ack_i),
		.stall_o        (stall_o),
		.tag_we_o       (tag_we),
		.tag_dirty_o    (tag_dirty),
		.ram_cs_o       (ram_cs),
		.fill_sel_o     (fill_sel),
		.word_we_o      (word_we),
		.mem_cs_o       (mem_cs_o),
		.mem_we_o       (mem_we_o),
		.mem_addr_o     (mem_addr_o)
	);

	sram #(
		.WIDTH (TAG_ENTRY_W),
		.DEPTH (`CACHE_SETS)
	) tag_ram_inst (
		.clk    (clk),
		.cs_i   (ram_cs),
		.we_i   (tag_we),
		.addr_i (req_index),
		.data_i (tag_wdata),
		.data_o (tag_rdata)
	);

	line_fill_router router_inst (
		.fill_sel_i    (fill_sel),
		.word_we_i     (word_we),
		.woff_i        (req_woff),
		.cpu_word_i    (data_i),
		.refill_line_i (mem_data_i),
		.bank_we_o     (bank_we),
		.bank_data_o   (bank_wdata)
	);

	// one word bank per line word, all share the index
	for (genvar k = 0; k < `CACHE_LINE_WORDS; k++) begin : g_bank
		sram #(
			.WIDTH (`CACHE_WORD_W),
			.DEPTH (`CACHE_SETS)
		) bank_inst (
			.clk    (clk),
			.cs_i   (ram_cs),
			.we_i   (bank_we[k]),
			.addr_i (req_index),
			.data_i (bank_wdata[k]),
			.data_o (bank_rdata[k])
		);
	end

	line_drain drain_inst (
		.woff_i       (req_woff),
		.bank_data_i  (bank_rdata),
		.data_o       (data_o),
		.evict_line_o (mem_data_o)
	);

endmodule

// File: l1_cache_controller.sv
`include "cache_defs.svh"

module l1_cache_controller
	import cache_pkg::*, mem_pkg::*;
(
	input  logic                     clk,
	input  logic                     arst_n_i,
	input  logic                     cs_i,
	input  logic                     we_i,
	input  tag_t                     tag_i,
	input  index_t                   index_i,
	input  tag_t                     stored_tag_i,
	input  logic                     stored_dirty_i,
	input  logic                     mem_ack_i,
	output logic                     stall_o,
	output logic                     tag_we_o,
	output logic                     tag_dirty_o,
	output logic                     ram_cs_o,
	output logic                     fill_sel_o,
	output logic                     word_we_o,
	output logic                     mem_cs_o,
	output logic                     mem_we_o,
	output logic [`CACHE_ADDR_W-1:0] mem_addr_o
);

	// byte offset within a line, zero on the memory port
	localparam int OFF_W = `CACHE_ADDR_W - `CACHE_TAG_W - `CACHE_INDEX_W;

	ctrl_state_e state_q;
	ctrl_state_e state_d;

	logic [`CACHE_SETS-1:0] valid_q;

	logic line_valid;
	logic hit;
	tag_t mem_tag;
	mem_op_e mem_op;

	// tag ram output is from the read issued in ST_IDLE
	assign line_valid = valid_q[index_i];
	assign hit = line_valid && (stored_tag_i == tag_i);

	always_comb begin
		state_d = state_q;
		stall_o = cs_i;
		tag_we_o = 1'b0;
		tag_dirty_o = 1'b0;
		ram_cs_o = 1'b0;
		fill_sel_o = 1'b0;
		word_we_o = 1'b0;
		mem_cs_o = 1'b0;
		mem_op = MEM_READ;

		case (state_q)
			ST_IDLE: begin
				// read tag and all banks at the request index
				if (cs_i) begin
					ram_cs_o = 1'b1;
					state_d = ST_COMPARE;
				end
			end

			ST_COMPARE: begin
				if (!cs_i) begin
					state_d = ST_IDLE;
				end else if (hit) begin
					stall_o = 1'b0;
					state_d = ST_IDLE;
					// write hit, one bank and mark the line dirty
					if (we_i) begin
						ram_cs_o = 1'b1;
						word_we_o = 1'b1;
						tag_we_o = 1'b1;
						tag_dirty_o = 1'b1;
					end
				end else if (line_valid && stored_dirty_i) begin
					state_d = ST_WRITE_BACK;
				end else begin
					state_d = ST_ALLOCATE;
				end
			end

			ST_WRITE_BACK: begin
				// bank outputs still hold the victim line
				mem_cs_o = 1'b1;
				mem_op = MEM_WRITE;
				if (mem_ack_i) begin
					state_d = ST_ALLOCATE;
				end
			end

			ST_ALLOCATE: begin
				mem_cs_o = 1'b1;
				if (mem_ack_i) begin
					// refill every bank, new tag goes in clean
					ram_cs_o = 1'b1;
					fill_sel_o = 1'b1;
					word_we_o = 1'b1;
					tag_we_o = 1'b1;
					state_d = ST_IDLE;
				end
			end

			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// valid bits in flops so reset invalidates the whole cache
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_q <= '0;
		end else if (tag_we_o && fill_sel_o) begin
			valid_q[index_i] <= 1'b1;
		end
	end

	// victim address on write back, request address otherwise
	assign mem_tag = (state_q == ST_WRITE_BACK) ? stored_tag_i : tag_i;
	assign mem_addr_o = {mem_tag, index_i, {OFF_W{1'b0}}};
	assign mem_we_o = mem_op;

endmodule

// File: line_drain.sv
`include "cache_defs.svh"

module line_drain
	import cache_pkg::*, mem_pkg::*;
(
	input  woff_t                         woff_i,
	input  word_t [`CACHE_LINE_WORDS-1:0] bank_data_i,
	output word_t                         data_o,
	output line_t                         evict_line_o
);

	// word for the cpu
	assign data_o = bank_data_i[woff_i];

	// victim line, bank k lands in word k
	always_comb begin
		for (int k = 0; k < `CACHE_LINE_WORDS; k++) begin
			evict_line_o[k*`CACHE_WORD_W +: `CACHE_WORD_W] = bank_data_i[k];
		end
	end

endmodule

// File: line_fill_router.sv
`include "cache_defs.svh"

module line_fill_router
	import cache_pkg::*, mem_pkg::*;
(
	input  logic                                fill_sel_i,
	input  logic                                word_we_i,
	input  woff_t                               woff_i,
	input  word_t                               cpu_word_i,
	input  line_t                               refill_line_i,
	output logic [`CACHE_LINE_WORDS-1:0]        bank_we_o,
	output word_t [`CACHE_LINE_WORDS-1:0]       bank_data_o
);

	always_comb begin
		for (int k = 0; k < `CACHE_LINE_WORDS; k++) begin
			if (fill_sel_i) begin
				// refill, every bank takes its slice of the line
				bank_we_o[k] = word_we_i;
				bank_data_o[k] = refill_line_i[k*`CACHE_WORD_W +: `CACHE_WORD_W];
			end else begin
				// cpu store hits only the addressed bank
				bank_we_o[k] = word_we_i && (woff_i == woff_t'(k));
				bank_data_o[k] = cpu_word_i;
			end
		end
	end

endmodule

// File: sram.sv
`include "cache_defs.svh"

module sram
	import cache_pkg::*;
#(
	parameter int WIDTH = `CACHE_WORD_W,
	parameter int DEPTH = `CACHE_SETS
)
(
	input  logic             clk,
	input  logic             cs_i,
	input  logic             we_i,
	input  index_t           addr_i,
	input  logic [WIDTH-1:0] data_i,
	output logic [WIDTH-1:0] data_o
);

	logic [WIDTH-1:0] mem_q [DEPTH];

	// single port, a write leaves the read register alone
	always_ff @(posedge clk) begin
		if (cs_i) begin
			if (we_i) begin
				mem_q[addr_i] <= data_i;
			end else begin
				data_o <= mem_q[addr_i];
			end
		end
	end

endmodule

// File: mem_pkg.sv
`include "cache_defs.svh"

package mem_pkg;

	// whole line as moved on the memory port, word k at bits 32k+31:32k
	typedef logic [`CACHE_LINE_W-1:0] line_t;

	// carried on mem_we_o
	typedef enum logic {
		MEM_READ = 1'b0,
		MEM_WRITE = 1'b1
	} mem_op_e;

endpackage

// File: cache_pkg.sv
`include "cache_defs.svh"

package cache_pkg;

	// controller states
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_COMPARE,
		ST_WRITE_BACK,
		ST_ALLOCATE
	} ctrl_state_e;

	// one cpu data word
	typedef logic [`CACHE_WORD_W-1:0] word_t;

	// address fields
	typedef logic [`CACHE_TAG_W-1:0] tag_t;
	typedef logic [`CACHE_INDEX_W-1:0] index_t;
	typedef logic [`CACHE_WOFF_W-1:0] woff_t;

endpackage

// File: cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// byte address and data word
`define CACHE_ADDR_W 32
`define CACHE_WORD_W 32

// line geometry
`define CACHE_LINE_WORDS 8
`define CACHE_LINE_W 256

// direct mapped, one line per set
`define CACHE_SETS 32

// address split: tag [31:10], index [9:5], word offset [4:2]
`define CACHE_TAG_W 22
`define CACHE_INDEX_W 5
`define CACHE_WOFF_W 3

`endif
